/* compile.f */
hw/ac97LinkPkg.sv
hw/ac97EntryPkg.sv
hw/ac97GrayCounter.sv
hw/ac97AsyncFifo.sv
hw/ac97FrameTimer.sv
hw/ac97SlotSerializer.sv
hw/ac97OutLink.sv
sim/ac97OutLink_assertions.sv
sim/ac97OutLinkTb.sv

/* hw/ac97AsyncFifo.sv */
//========================================
// Two clock FIFO, Gray pointers
//========================================

`timescale 1ns/1ps
`default_nettype none

module ac97AsyncFifo #(
    parameter int DataWidth = 33,
    parameter int AddressWidth = 4
) (
    input  logic                 WClk,
    input  logic                 RClk,
    input  logic                 clear,
    input  logic                 writeEn,
    input  logic [DataWidth-1:0] writeData,
    output logic                 full,
    input  logic                 readEn,
    output logic [DataWidth-1:0] readData,
    output logic                 empty
);

    localparam int Depth = 1 << AddressWidth;

    // Dual port storage, written on WClk only
    logic [DataWidth-1:0] mem [Depth];

    // Gray pointers, next slot to write and to read
    logic [AddressWidth-1:0] writePointer;
    logic [AddressWidth-1:0] readPointer;

    logic writeAccept;
    logic readAccept;
    logic equalAddresses;
    logic setStatus;
    logic rstStatus;
    // Set means going full, clear means going empty
    logic status;
    logic presetFull;
    logic presetEmptyFlag;

    // ========================================
    // Data path
    // ========================================

    // Read port is combinational at the read pointer
    assign readData = mem[readPointer];

    always_ff @(posedge WClk) begin
        if (writeAccept) begin
            mem[writePointer] <= writeData;
        end
    end

    // Blocked requests leave the pointers alone
    assign writeAccept = writeEn & ~full;
    assign readAccept = readEn & ~empty;

    ac97GrayCounter #(
        .CounterWidth(AddressWidth)
    ) writeCounter (
        .clk(WClk),
        .clear(clear),
        .enable(writeAccept),
        .grayCount(writePointer)
    );

    ac97GrayCounter #(
        .CounterWidth(AddressWidth)
    ) readCounter (
        .clk(RClk),
        .clear(clear),
        .enable(readAccept),
        .grayCount(readPointer)
    );

    // ========================================
    // Status and flags
    // ========================================

    assign equalAddresses = (writePointer == readPointer);

    // Writer one quadrant behind the reader
    assign setStatus =
        (writePointer[AddressWidth-2] ~^ readPointer[AddressWidth-1]) &
        (writePointer[AddressWidth-1] ^ readPointer[AddressWidth-2]);

    // Writer one quadrant ahead of the reader
    assign rstStatus =
        (writePointer[AddressWidth-2] ^ readPointer[AddressWidth-1]) &
        (writePointer[AddressWidth-1] ~^ readPointer[AddressWidth-2]);

    // Direction latch, clear wins over set
    always_latch begin
        if (rstStatus | clear) begin
            status = 1'b0;
        end else if (setStatus) begin
            status = 1'b1;
        end
    end

    // Equal pointers, direction picks full or empty
    assign presetFull = status & equalAddresses;
    assign presetEmptyFlag = ~status & equalAddresses;

    // Full goes up at once, drops on the write clock
    always_ff @(posedge WClk or posedge presetFull) begin
        if (presetFull) begin
            full <= 1'b1;
        end else begin
            full <= 1'b0;
        end
    end

    // Empty goes up at once, drops on the read clock
    always_ff @(posedge RClk or posedge presetEmptyFlag) begin
        if (presetEmptyFlag) begin
            empty <= 1'b1;
        end else begin
            empty <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hw/ac97EntryPkg.sv */
//========================================
// Host entry format
//========================================

`default_nettype none

package ac97EntryPkg;

    // Stereo sample pair, left in the upper half
    typedef struct packed {
        logic [15:0] left;
        logic [15:0] right;
    } PcmPayload;

    // Codec register access
    typedef struct packed {
        logic        readWrite;
        logic [6:0]  regIndex;
        // Unused, keeps data in the low half
        logic [7:0]  pad;
        logic [15:0] data;
    } CmdPayload;

    // Same 32 bits, read as PCM or as a command
    typedef union packed {
        PcmPayload pcm;
        CmdPayload cmd;
    } EntryPayload;

    // Kind bit sits above the payload
    localparam int EntryKindBit = $bits(EntryPayload);
    localparam int EntryWidth = $bits(EntryPayload) + 1;

    // readWrite value that requests a register read
    localparam logic CmdRead = 1'b1;

endpackage

`default_nettype wire

/* hw/ac97FrameTimer.sv */
//========================================
// AC97 frame bit timer
//========================================

`timescale 1ns/1ps
`default_nettype none

module ac97FrameTimer (
    input  logic RClk,
    input  logic PresetEmpty,
    output logic frameStart,
    output logic sync
);

    localparam int CountWidth = ac97LinkPkg::BitCountWidth;

    // Last bit of the frame
    localparam logic [CountWidth-1:0] LastIndex =
        CountWidth'(ac97LinkPkg::FrameBits - 1);

    // Sync covers indices below this
    localparam logic [CountWidth-1:0] SyncLimit =
        CountWidth'(ac97LinkPkg::SyncBits);

    // Index of the bit now on sdataOut
    logic [CountWidth-1:0] bitIndex;
    logic [CountWidth-1:0] nextIndex;

    // Wraps 255 to 0 by width
    assign nextIndex = bitIndex + 1'b1;

    // Serializer loads the next frame on this cycle
    assign frameStart = (bitIndex == LastIndex);

    // Counter starts on the last bit, first edge opens a frame
    always_ff @(posedge RClk or posedge PresetEmpty) begin
        if (PresetEmpty) begin
            bitIndex <= LastIndex;
            sync <= 1'b0;
        end else begin
            bitIndex <= nextIndex;
            // Registered so it lines up with the output bit
            sync <= (nextIndex < SyncLimit);
        end
    end

endmodule

`default_nettype wire

/* hw/ac97GrayCounter.sv */
//========================================
// Gray code pointer counter
//========================================

`timescale 1ns/1ps
`default_nettype none

module ac97GrayCounter #(
    parameter int CounterWidth = 4
) (
    input  logic                    clk,
    input  logic                    clear,
    input  logic                    enable,
    output logic [CounterWidth-1:0] grayCount
);

    // Binary shadow of the pointer
    logic [CounterWidth-1:0] binaryCount;
    logic [CounterWidth-1:0] binaryNext;
    logic [CounterWidth-1:0] grayNext;

    // Next binary value and its Gray form
    assign binaryNext = binaryCount + 1'b1;
    assign grayNext = binaryNext ^ (binaryNext >> 1);

    // Both copies move together, so they never disagree
    always_ff @(posedge clk) begin
        if (clear) begin
            // Start of the ring, Gray of zero is zero
            binaryCount <= '0;
            grayCount <= '0;
        end else if (enable) begin
            binaryCount <= binaryNext;
            // Only one bit flips per step
            grayCount <= grayNext;
        end
    end

endmodule

`default_nettype wire

/* hw/ac97LinkPkg.sv */
//========================================
// AC97 output frame format
//========================================

`default_nettype none

package ac97LinkPkg;

    // ========================================
    // Frame geometry
    // ========================================

    // Whole frame, tag slot plus twelve data slots
    localparam int FrameBits = 256;

    // Slot 0 carries the tag
    localparam int TagBits = 16;

    // Slots 1 to 12 are all the same width
    localparam int SlotBits = 20;

    // Sync stays high over the tag slot only
    localparam int SyncBits = 16;

    // Enough to index every bit of a frame
    localparam int BitCountWidth = 8;

    // ========================================
    // Tag bit positions
    // ========================================

    // Frame valid flag, first bit on the wire
    localparam int TagFrameValid = 15;

    // Per-slot valid flag, slot n at bit 15 - n
    function automatic int TagSlotValid(input int slot);
        return TagFrameValid - slot;
    endfunction

endpackage

`default_nettype wire

/* hw/ac97OutLink.sv */
//========================================
// AC97 transmit link top
//========================================

`timescale 1ns/1ps
`default_nettype none

module ac97OutLink #(
    parameter int AddressWidth = 4
) (
    input  logic                      WClk,
    input  logic                      RClk,
    input  logic                      PresetEmpty,
    input  logic                      writeEn,
    input  ac97EntryPkg::EntryPayload writeData,
    input  logic                      writeIsCommand,
    output logic                      full,
    output logic                      sdataOut,
    output logic                      sync
);

    // Read side of the FIFO, bit clock domain
    logic [ac97EntryPkg::EntryWidth-1:0] fifoData;
    logic fifoEmpty;
    logic fifoRead;

    // High during the last bit of each frame
    logic frameStart;

    // ========================================
    // Clock crossing
    // ========================================

    // Kind bit rides on top of the payload
    ac97AsyncFifo #(
        .DataWidth(ac97EntryPkg::EntryWidth),
        .AddressWidth(AddressWidth)
    ) entryFifo (
        .WClk(WClk),
        .RClk(RClk),
        .clear(PresetEmpty),
        .writeEn(writeEn),
        .writeData({writeIsCommand, writeData}),
        .full(full),
        .readEn(fifoRead),
        .readData(fifoData),
        .empty(fifoEmpty)
    );

    // ========================================
    // Bit clock side
    // ========================================

    ac97FrameTimer frameTimer (
        .RClk(RClk),
        .PresetEmpty(PresetEmpty),
        .frameStart(frameStart),
        .sync(sync)
    );

    ac97SlotSerializer slotSerializer (
        .RClk(RClk),
        .PresetEmpty(PresetEmpty),
        .frameStart(frameStart),
        .fifoData(fifoData),
        .fifoEmpty(fifoEmpty),
        .fifoRead(fifoRead),
        .sdataOut(sdataOut)
    );

endmodule

`default_nettype wire

/* hw/ac97SlotSerializer.sv */
//========================================
// AC97 slot builder and shifter
//========================================

`timescale 1ns/1ps
`default_nettype none

module ac97SlotSerializer (
    input  logic                               RClk,
    input  logic                               PresetEmpty,
    input  logic                               frameStart,
    input  logic [ac97EntryPkg::EntryWidth-1:0] fifoData,
    input  logic                               fifoEmpty,
    output logic                               fifoRead,
    output logic                               sdataOut
);

    localparam int FrameBits = ac97LinkPkg::FrameBits;
    localparam int TagBits = ac97LinkPkg::TagBits;
    localparam int SlotBits = ac97LinkPkg::SlotBits;
    // Low pad below a 16 bit field in a slot
    localparam int LowPadBits = SlotBits - 16;
    // Slots 5 to 12 are always zero
    localparam int FillBits = FrameBits - TagBits - 4 * SlotBits;

    ac97EntryPkg::EntryPayload payload;
    logic isCommand;

    logic [TagBits-1:0]  tagWord;
    logic [SlotBits-1:0] slot1Word;
    logic [SlotBits-1:0] slot2Word;
    logic [SlotBits-1:0] slot3Word;
    logic [SlotBits-1:0] slot4Word;

    // Outgoing frame, MSB first
    logic [FrameBits-1:0] shiftReg;

    // ========================================
    // Entry decode
    // ========================================

    assign isCommand = fifoData[ac97EntryPkg::EntryKindBit];
    assign payload = fifoData[ac97EntryPkg::EntryKindBit-1:0];

    // One entry per frame, taken on the frame boundary
    assign fifoRead = frameStart & ~fifoEmpty;

    always_comb begin
        tagWord = '0;
        slot1Word = '0;
        slot2Word = '0;
        slot3Word = '0;
        slot4Word = '0;
        // Nothing queued means an all zero frame, tag too
        if (!fifoEmpty) begin
            tagWord[ac97LinkPkg::TagFrameValid] = 1'b1;
            if (isCommand) begin
                // Command address and data slots
                tagWord[ac97LinkPkg::TagSlotValid(1)] = 1'b1;
                tagWord[ac97LinkPkg::TagSlotValid(2)] = 1'b1;
                // Bit 19 high requests a read
                slot1Word = {
                    payload.cmd.readWrite == ac97EntryPkg::CmdRead,
                    payload.cmd.regIndex,
                    {(SlotBits - 8){1'b0}}
                };
                // Data goes out even for a read
                slot2Word = {payload.cmd.data, {LowPadBits{1'b0}}};
            end else begin
                // PCM left and right
                tagWord[ac97LinkPkg::TagSlotValid(3)] = 1'b1;
                tagWord[ac97LinkPkg::TagSlotValid(4)] = 1'b1;
                // 16 bit samples, left justified in 20
                slot3Word = {payload.pcm.left, {LowPadBits{1'b0}}};
                slot4Word = {payload.pcm.right, {LowPadBits{1'b0}}};
            end
        end
    end

    // ========================================
    // Frame shifter
    // ========================================

    // Load on frameStart, so bit 0 is out right after
    always_ff @(posedge RClk or posedge PresetEmpty) begin
        if (PresetEmpty) begin
            shiftReg <= '0;
        end else if (frameStart) begin
            shiftReg <= {
                tagWord,
                slot1Word,
                slot2Word,
                slot3Word,
                slot4Word,
                {FillBits{1'b0}}
            };
        end else begin
            shiftReg <= {shiftReg[FrameBits-2:0], 1'b0};
        end
    end

    assign sdataOut = shiftReg[FrameBits-1];

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build the AC97 link testbench with Verilator and run it
verilator --binary --assert -f compile.f --top-module ac97OutLinkTb -o ac97OutLinkSim \
    && ./obj_dir/ac97OutLinkSim \
    || exit $?

/* sim/ac97OutLinkTb.sv */
//========================================
// AC97 transmit link testbench
//========================================

`timescale 1ns/1ps
`default_nettype none

module ac97OutLinkTb;

    localparam int FrameBits = 256;
    localparam int WClkHalf = 10;
    localparam int RClkHalf = 41;
    // Frames the tests wait for, plus one start-up frame per test
    localparam int TotalFrames = 50;
    // Whole run in ns, 20 percent slack
    localparam int WatchdogNs = TotalFrames * FrameBits * 2 * RClkHalf * 12 / 10;

    logic WClk;
    logic RClk;
    logic PresetEmpty;
    logic writeEn;
    ac97EntryPkg::EntryPayload writeData;
    logic writeIsCommand;
    logic full;
    logic sdataOut;
    logic sync;

    int seed;
    // Captured frames, oldest first
    logic [FrameBits-1:0] frameQueue[$];
    // Entries due on the link, kind bit on top
    logic [32:0] expectedQueue[$];

    ac97OutLink #(
        .AddressWidth(4)
    ) dut (
        .WClk(WClk),
        .RClk(RClk),
        .PresetEmpty(PresetEmpty),
        .writeEn(writeEn),
        .writeData(writeData),
        .writeIsCommand(writeIsCommand),
        .full(full),
        .sdataOut(sdataOut),
        .sync(sync)
    );

    // ========================================
    // Clocks and frame capture
    // ========================================

    initial begin
        WClk = 1'b0;
        forever #(WClkHalf) WClk = ~WClk;
    end

    // First edge falls inside reset, clears the read pointer
    initial begin
        RClk = 1'b0;
        #15;
        forever begin
            RClk = 1'b1;
            #(RClkHalf);
            RClk = 1'b0;
            #(RClkHalf);
        end
    end

    task automatic checkValue(input string testName, input logic [FrameBits-1:0] expected,
                              input logic [FrameBits-1:0] actual);
        if (actual !== expected) begin
            $display("Mismatch in %s: expected %0h, actual %0h", testName, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "check failed");
        end
    endtask

    // Mid-bit sampling, frame opens on sync rising
    initial begin : deserializer
        logic [FrameBits-1:0] capture;
        int bitCount;
        int syncCount;
        int sinceRise;
        logic seenRise;
        logic inFrame;
        logic lastSync;
        capture = '0;
        bitCount = 0;
        syncCount = 0;
        sinceRise = 0;
        seenRise = 1'b0;
        inFrame = 1'b0;
        lastSync = 1'b0;
        forever begin
            @(negedge RClk);
            if (sync && !lastSync) begin
                // Sync period is one frame, short or long
                if (seenRise) begin
                    checkValue("frameLength", FrameBits'(FrameBits), FrameBits'(sinceRise));
                end
                seenRise = 1'b1;
                sinceRise = 0;
                inFrame = 1'b1;
                bitCount = 0;
                syncCount = 0;
            end
            sinceRise++;
            if (inFrame) begin
                capture = {capture[FrameBits-2:0], sdataOut};
                syncCount += int'(sync);
                bitCount++;
                if (bitCount == FrameBits) begin
                    checkValue("syncWidth", FrameBits'(16), FrameBits'(syncCount));
                    frameQueue.push_back(capture);
                    inFrame = 1'b0;
                end
            end
            lastSync = sync;
        end
    end

    initial begin : watchdog
        #(WatchdogNs);
        $display("Timeout: the link did not deliver the expected frames in time");
        $display("=== FAIL ===");
        $fatal(1, "watchdog expired");
    end

    // ========================================
    // Stimulus and frame model
    // ========================================

    // Tag, slots 1 to 4, then 160 zero bits
    function automatic logic [FrameBits-1:0] expectedFrame(input logic [32:0] entry);
        logic [15:0] tag;
        logic [19:0] slot1;
        logic [19:0] slot2;
        logic [19:0] slot3;
        logic [19:0] slot4;
        slot1 = '0;
        slot2 = '0;
        slot3 = '0;
        slot4 = '0;
        if (entry[32]) begin
            // Frame valid, slots 1 and 2 valid
            tag = 16'hE000;
            slot1 = {entry[31], entry[30:24], 12'h000};
            slot2 = {entry[15:0], 4'h0};
        end else begin
            // Frame valid, slots 3 and 4 valid
            tag = 16'h9800;
            slot3 = {entry[31:16], 4'h0};
            slot4 = {entry[15:0], 4'h0};
        end
        return {tag, slot1, slot2, slot3, slot4, 160'h0};
    endfunction

    task automatic pushEntry(input logic isCommand, input logic [31:0] payload);
        @(negedge WClk);
        writeEn = 1'b1;
        writeIsCommand = isCommand;
        writeData = payload;
    endtask

    task automatic sendEntry(input logic isCommand, input logic [31:0] payload);
        expectedQueue.push_back({isCommand, payload});
        pushEntry(isCommand, payload);
    endtask

    task automatic stopWrites();
        @(negedge WClk);
        writeEn = 1'b0;
    endtask

    task automatic startTest();
        frameQueue.delete();
        expectedQueue.delete();
    endtask

    // Up to two idle frames lead, then entries back to back, then idle
    task automatic checkFrames(input string testName);
        int needed;
        int skipped;
        int index;
        needed = expectedQueue.size() + 3;
        skipped = 0;
        while (frameQueue.size() < needed) begin
            @(posedge RClk);
        end
        while (skipped < 2 && expectedQueue.size() > 0 && frameQueue[0] == '0) begin
            void'(frameQueue.pop_front());
            skipped++;
        end
        for (index = 0; expectedQueue.size() > 0; index++) begin
            checkValue($sformatf("%s entry %0d", testName, index),
                       expectedFrame(expectedQueue.pop_front()), frameQueue.pop_front());
        end
        while (frameQueue.size() > 0) begin
            checkValue($sformatf("%s trailing idle", testName), '0, frameQueue.pop_front());
        end
    endtask

    // ========================================
    // Tests
    // ========================================

    task automatic testIdleFrames();
        startTest();
        checkFrames("idleFrames");
    endtask

    task automatic testPcmEntry();
        startTest();
        sendEntry(1'b0, $random(seed));
        stopWrites();
        checkFrames("pcmEntry");
    endtask

    task automatic testCommandEntries();
        logic [31:0] payload;
        startTest();
        payload = $random(seed);
        payload[31] = 1'b0;
        sendEntry(1'b1, payload);
        // Read command still carries its data field
        payload = $random(seed);
        payload[31] = 1'b1;
        sendEntry(1'b1, payload);
        stopWrites();
        checkFrames("commandEntries");
    endtask

    task automatic testOrdering();
        logic [31:0] kindBits;
        startTest();
        for (int i = 0; i < 10; i++) begin
            kindBits = $random(seed);
            sendEntry(kindBits[0], $random(seed));
        end
        stopWrites();
        checkFrames("ordering");
    endtask

    // 18 writes take 360 ns, no frame boundary in between
    task automatic testFullAndDrop();
        logic [31:0] kindBits;
        startTest();
        @(posedge sync);
        for (int i = 0; i < 18; i++) begin
            kindBits = $random(seed);
            if (i < 16) begin
                sendEntry(kindBits[0], $random(seed));
            end else begin
                pushEntry(kindBits[0], $random(seed));
            end
            checkValue($sformatf("fullFlag before write %0d", i),
                       FrameBits'(i >= 16), FrameBits'(full));
        end
        stopWrites();
        checkValue("fullFlag after burst", FrameBits'(1), FrameBits'(full));
        // First pop lands just before the next sync rise
        @(posedge sync);
        repeat (2) @(negedge WClk);
        checkValue("fullFlag after first read", '0, FrameBits'(full));
        checkFrames("fullAndDrop");
    endtask

    initial begin : mainSequence
        seed = 32'hbee8;
        PresetEmpty = 1'b1;
        writeEn = 1'b0;
        writeData = '0;
        writeIsCommand = 1'b0;
        // Two full WClk cycles, released on a falling edge
        repeat (2) @(posedge WClk);
        @(negedge WClk);
        PresetEmpty = 1'b0;
        testIdleFrames();
        testPcmEntry();
        testCommandEntries();
        testOrdering();
        testFullAndDrop();
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

/* sim/ac97OutLink_assertions.sv */
//========================================
// Slot serializer checks
//========================================

`timescale 1ns/1ps
`default_nettype none

module ac97OutLinkAssertions (
    input logic RClk,
    input logic PresetEmpty,
    input logic frameStart,
    input logic fifoEmpty,
    input logic fifoRead,
    input logic sdataOut
);

    localparam int CountWidth = ac97LinkPkg::BitCountWidth;
    localparam logic [CountWidth-1:0] LastIndex =
        CountWidth'(ac97LinkPkg::FrameBits - 1);

    // Frame now on the wire was loaded with nothing queued
    logic idleFrame;

    // Own count of the frame position, apart from the timer
    logic [CountWidth-1:0] framePos;

    always_ff @(posedge RClk or posedge PresetEmpty) begin
        if (PresetEmpty) begin
            idleFrame <= 1'b0;
        end else if (frameStart) begin
            idleFrame <= fifoEmpty;
        end
    end

    // Same start point as the bit counter, last bit of a frame
    always_ff @(posedge RClk or posedge PresetEmpty) begin
        if (PresetEmpty) begin
            framePos <= LastIndex;
        end else begin
            framePos <= framePos + 1'b1;
        end
    end

    // Never pop an empty FIFO
    noReadWhenEmpty: assert property (
        @(posedge RClk) disable iff (PresetEmpty) !(fifoRead && fifoEmpty)
    ) else $error("fifoRead high while fifoEmpty is high");

    // Pops only on the last bit of a frame
    readOnFrameStart: assert property (
        @(posedge RClk) disable iff (PresetEmpty) fifoRead |-> (framePos == LastIndex)
    ) else $error("fifoRead high away from the frame boundary");

    // Idle frame keeps the line low up to its last bit
    quietIdleFrame: assert property (
        @(posedge RClk) disable iff (PresetEmpty) idleFrame |-> !sdataOut
    ) else $error("sdataOut high during an idle frame");

endmodule

bind ac97SlotSerializer ac97OutLinkAssertions serializerChecks (
    .RClk(RClk),
    .PresetEmpty(PresetEmpty),
    .frameStart(frameStart),
    .fifoEmpty(fifoEmpty),
    .fifoRead(fifoRead),
    .sdataOut(sdataOut)
);

`default_nettype wire
